//--- bench/clk_gen.sv
//**********************************************************
// testbench clock and power-on reset
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset falls just after power-up, held for RST_CYCLES rising edges
	initial begin
		rst_n = 1'b1;
		#1;
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/dispatch_checker.sv
//**********************************************************
// handshake assertions bound into the dispatch stage top
// issue pushes, reset behavior and the commit guard
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module dispatch_checker (
	input logic clk,
	input logic rst_n,
	input logic in_ready,
	input logic alu_push,
	input logic alu_full,
	input logic bru_push,
	input logic bru_full,
	input logic lu_push,
	input logic lu_full,
	input logic su_push,
	input logic su_full,
	input logic commit_valid,
	input logic rob_empty
);

	// no push into a full issue queue
	a_alu_full: assert property (@(posedge clk) disable iff (!rst_n) alu_push |-> !alu_full)
		else $error("alu_push with alu_full high");
	a_bru_full: assert property (@(posedge clk) disable iff (!rst_n) bru_push |-> !bru_full)
		else $error("bru_push with bru_full high");
	a_lu_full: assert property (@(posedge clk) disable iff (!rst_n) lu_push |-> !lu_full)
		else $error("lu_push with lu_full high");
	a_su_full: assert property (@(posedge clk) disable iff (!rst_n) su_push |-> !su_full)
		else $error("su_push with su_full high");

	a_one_push: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({alu_push, bru_push, lu_push, su_push}))
		else $error("more than one issue push in a cycle");

	a_reset_ready: assert property (@(posedge clk) !rst_n |-> !in_ready)
		else $error("in_ready high during reset");

	// the reorder FIFO does not guard its own pop
	a_commit: assert property (@(posedge clk) disable iff (!rst_n) commit_valid |-> !rob_empty)
		else $error("commit with the reorder queue empty");

endmodule

bind dispatch_top dispatch_checker chk (
	.clk(clk), .rst_n(rst_n), .in_ready(in_ready),
	.alu_push(alu_push), .alu_full(alu_full), .bru_push(bru_push), .bru_full(bru_full),
	.lu_push(lu_push), .lu_full(lu_full), .su_push(su_push), .su_full(su_full),
	.commit_valid(commit_valid), .rob_empty(rob_empty)
);

`default_nettype wire

//--- bench/dispatch_tb.sv
//**********************************************************
// testbench for the dispatch stage
// directed tests against a reference model of renaming
// and of the reorder queue, with a cycle timeout
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module dispatch_tb
	import uop_pkg::*, rename_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 2000;

	typedef struct packed {
		uop_class_t cls;
		func_t      func;
		pc_t        pc;
		imm_t       imm;
		arch_reg_t  rd;
		arch_reg_t  rs1;
		arch_reg_t  rs2;
	} uop_rec_t;

	typedef struct packed {
		pc_t       pc;
		logic      has_rd;
		phys_tag_t new_tag;
		phys_tag_t prev_tag;
	} rob_rec_t;

	logic       clk, rst_n;
	logic       in_valid, in_ready;
	uop_class_t in_class;
	func_t      in_func, iq_func;
	pc_t        in_pc, iq_pc, commit_pc;
	imm_t       in_imm, iq_imm;
	arch_reg_t  in_rd, in_rs1, in_rs2;
	phys_tag_t  iq_rd_tag, iq_rs1_tag, iq_rs2_tag, commit_rd_tag;
	logic       alu_push, alu_full, bru_push, bru_full;
	logic       lu_push, lu_full, su_push, su_full;
	logic       st_pending, ld_pending, commit_valid, rob_empty;

	// reference model state
	copy_idx_t            act_m  [32];
	logic [RN_COPIES-1:0] busy_m [32];
	uop_rec_t             exp_q  [$];
	rob_rec_t             rob_m  [$];

	int        err_count  = 0;
	int        check_cnt  = 0;
	int        push_cnt   = 0;
	int        commit_cnt = 0;
	int        cycles     = 0;
	phys_tag_t last_rd_tag;
	pc_t       next_pc;

	clk_gen #(.PERIOD(10), .RST_CYCLES(2)) clkgen (.clk(clk), .rst_n(rst_n));

	dispatch_top #(.IQ_DEPTH(4), .ROB_DEPTH(8)) uut (.*);

	function automatic void check_val(string name, logic [63:0] got, logic [63:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endfunction

	function automatic void check_true(logic ok, string what);
		check_cnt++;
		assert (ok) else begin
			$display("check failed: %s", what);
			err_count++;
		end
	endfunction

	function automatic copy_idx_t lowest_free(arch_reg_t r);
		copy_idx_t c;
		logic      found;
		c = '0;
		found = 1'b0;
		for (int i = 0; i < RN_COPIES; i++) begin
			if (!found && !busy_m[r][i]) begin
				c = copy_idx_t'(i);
				found = 1'b1;
			end
		end
		return c;
	endfunction

	// predict tags for the oldest waiting micro-op, then book its copy
	function automatic void check_push();
		uop_rec_t   e;
		rob_rec_t   r;
		uop_class_t got_cls;
		copy_idx_t  free_c;
		phys_tag_t  exp_rd;
		push_cnt++;
		got_cls = alu_push ? CLS_ALU : bru_push ? CLS_BRU : lu_push ? CLS_LU : CLS_SU;
		if (exp_q.size() == 0) begin
			check_true(1'b0, "issue push with no micro-op waiting");
			return;
		end
		e = exp_q.pop_front();
		free_c = lowest_free(e.rd);
		exp_rd = (e.rd == '0) ? '0 : {e.rd, free_c};
		check_true(e.rd == '0 || !(&busy_m[e.rd]), "push for a register with no free copy");
		check_val("issue push class", 64'(got_cls), 64'(e.cls));
		check_val("iq_func", 64'(iq_func), 64'(e.func));
		check_val("iq_pc", iq_pc, e.pc);
		check_val("iq_imm", iq_imm, e.imm);
		check_val("iq_rs1_tag", 64'(iq_rs1_tag), 64'({e.rs1, act_m[e.rs1]}));
		check_val("iq_rs2_tag", 64'(iq_rs2_tag), 64'({e.rs2, act_m[e.rs2]}));
		check_val("iq_rd_tag", 64'(iq_rd_tag), 64'(exp_rd));
		last_rd_tag = iq_rd_tag;
		r.pc       = e.pc;
		r.has_rd   = (e.rd != '0);
		r.new_tag  = exp_rd;
		r.prev_tag = {e.rd, act_m[e.rd]};
		rob_m.push_back(r);
		if (e.rd != '0) begin
			busy_m[e.rd][free_c] = 1'b1;
			act_m[e.rd] = free_c;
		end
	endfunction

	function automatic void check_commit();
		rob_rec_t r;
		commit_cnt++;
		if (rob_m.size() == 0) begin
			check_true(1'b0, "commit with no reorder entry in the model");
			return;
		end
		r = rob_m.pop_front();
		check_val("commit_pc", commit_pc, r.pc);
		check_val("commit_rd_tag", 64'(commit_rd_tag), 64'(r.new_tag));
		if (r.has_rd) begin
			busy_m[r.prev_tag[TAG_W-1:CP_W]][r.prev_tag[CP_W-1:0]] = 1'b0;
		end
	endfunction

	// pushes and commits seen at negedge take effect on the next rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (alu_push || bru_push || lu_push || su_push) begin
				check_push();
			end
			if (commit_valid && !rob_empty) begin
				check_commit();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// called and returns one delay step after a rising edge
	task automatic send(uop_class_t cls, func_t func, arch_reg_t rd,
			arch_reg_t rs1, arch_reg_t rs2, imm_t imm);
		uop_rec_t e;
		in_valid = 1'b1;
		in_class = cls;
		in_func  = func;
		in_pc    = next_pc;
		in_imm   = imm;
		in_rd    = rd;
		in_rs1   = rs1;
		in_rs2   = rs2;
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		if (cls == CLS_ALU || cls == CLS_BRU || cls == CLS_LU || cls == CLS_SU) begin
			e.cls  = cls;
			e.func = func;
			e.pc   = next_pc;
			e.imm  = imm;
			e.rd   = rd;
			e.rs1  = rs1;
			e.rs2  = rs2;
			exp_q.push_back(e);
		end
		next_pc = next_pc + 64'd4;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_pushes(int n);
		while (push_cnt < n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic commit_one();
		commit_valid = 1'b1;
		@(posedge clk);
		#1;
		commit_valid = 1'b0;
	endtask

	task automatic retire_all();
		while (!rob_empty) begin
			commit_valid = 1'b1;
			@(posedge clk);
			#1;
		end
		commit_valid = 1'b0;
		check_true(rob_m.size() == 0, "reorder queue empty while the model still holds entries");
	endtask

	function automatic void report_test(string name, int errs_before);
		$display("test %-26s errors %0d", name, err_count - errs_before);
	endfunction

	task automatic test_independent();
		int e0;
		e0 = err_count;
		for (int i = 0; i < 6; i++) begin
			send(CLS_ALU, FN_ADD, arch_reg_t'(10 + i), arch_reg_t'(20 + i),
				arch_reg_t'(26 + i), 64'(i));
		end
		wait_drain();
		retire_all();
		report_test("independent alu ops", e0);
	endtask

	task automatic test_chain();
		int e0;
		e0 = err_count;
		send(CLS_ALU, FN_ADD, 5'd7, 5'd1, 5'd2, 64'd0);
		send(CLS_LU,  FN_LD,  5'd8, 5'd7, 5'd0, 64'd16);
		send(CLS_ALU, FN_XOR, 5'd9, 5'd8, 5'd7, 64'd0);
		// store and branch write x0
		send(CLS_SU,  FN_SD,  5'd0, 5'd9, 5'd8, 64'd8);
		send(CLS_BRU, FN_BEQ, 5'd0, 5'd9, 5'd7, 64'h40);
		send(CLS_ALU, FN_SUB, 5'd7, 5'd7, 5'd9, 64'd0);
		wait_drain();
		retire_all();
		report_test("dependency chain", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		int hold;
		int base;
		e0 = err_count;
		hold = 5 + int'($urandom % 16);
		alu_full = 1'b1;
		base = push_cnt;
		send(CLS_ALU, FN_SLL, 5'd3, 5'd7, 5'd9, 64'd2);
		send(CLS_LU, FN_LW, 5'd4, 5'd3, 5'd0, 64'd4);
		repeat (hold) @(posedge clk);
		#1;
		check_true(push_cnt == base, "issue push while the alu queue head was blocked");
		alu_full = 1'b0;
		wait_drain();
		retire_all();
		report_test("alu back-pressure", e0);
	endtask

	task automatic test_exhaust();
		int e0;
		int base;
		e0 = err_count;
		base = push_cnt;
		for (int i = 0; i < 4; i++) begin
			send(CLS_ALU, FN_ADD, 5'd5, 5'd5, 5'd0, 64'(i + 1));
		end
		wait_pushes(base + 3);
		repeat (5) @(posedge clk);
		#1;
		check_true(push_cnt == base + 3, "fourth write to x5 issued with no free copy");
		// retiring the first write frees copy 0
		commit_one();
		wait_drain();
		check_val("iq_rd_tag", 64'(last_rd_tag), 64'({5'd5, 2'd0}));
		retire_all();
		report_test("copy exhaustion", e0);
	endtask

	task automatic test_fence();
		int e0;
		int base;
		int c0;
		e0 = err_count;
		st_pending = 1'b1;
		ld_pending = 1'b1;
		// fence w, rw
		send(CLS_FENCE, 6'd0, 5'd0, 5'd0, 5'd0, 64'h13);
		send(CLS_ALU, FN_ADD, 5'd10, 5'd11, 5'd12, 64'd0);
		base = push_cnt;
		repeat (8) @(posedge clk);
		#1;
		check_true(push_cnt == base, "alu op issued past a held fence");
		// loads alone do not hold a write predecessor
		st_pending = 1'b0;
		wait_drain();
		ld_pending = 1'b0;
		c0 = commit_cnt;
		retire_all();
		check_true(commit_cnt - c0 == 1, "fence took a reorder entry");
		send(CLS_UNSUP, 6'd0, 5'd1, 5'd2, 5'd3, 64'd0);
		send(CLS_ALU, FN_XOR, 5'd11, 5'd10, 5'd1, 64'd0);
		wait_drain();
		c0 = commit_cnt;
		retire_all();
		check_true(commit_cnt - c0 == 1, "unsupported op took a reorder entry");
		report_test("fence and unsupported", e0);
	endtask

	initial begin
		int seed;
		seed = $urandom(32'h579b);
		in_valid     = 1'b0;
		in_class     = CLS_ALU;
		in_func      = '0;
		in_pc        = '0;
		in_imm       = '0;
		in_rd        = '0;
		in_rs1       = '0;
		in_rs2       = '0;
		alu_full     = 1'b0;
		bru_full     = 1'b0;
		lu_full      = 1'b0;
		su_full      = 1'b0;
		st_pending   = 1'b0;
		ld_pending   = 1'b0;
		commit_valid = 1'b0;
		next_pc      = 64'h1000;
		// after reset every register sits on copy 0
		for (int r = 0; r < 32; r++) begin
			act_m[r]  = '0;
			busy_m[r] = RN_COPIES'(1);
		end
		@(negedge rst_n);
		@(posedge rst_n);
		@(posedge clk);
		#1;
		test_independent();
		test_chain();
		test_backpressure();
		test_exhaust();
		test_fence();
		check_true(exp_q.size() == 0 && rob_m.size() == 0, "micro-ops left over at the end");
		$display("checks %0d, errors %0d", check_cnt, err_count);
		if (err_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/uop_pkg.sv
rtl/rename_pkg.sv
rtl/sync_fifo.sv
rtl/rename.sv
rtl/dispatch.sv
rtl/dispatch_top.sv
bench/clk_gen.sv
bench/dispatch_checker.sv
bench/dispatch_tb.sv

//--- rtl/dispatch.sv
//**********************************************************
// dispatch control
// routes the instruction queue head to one issue queue,
// holds fences on outstanding memory work, drops unsupported
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module dispatch
	import uop_pkg::*;
(
	input  logic [UOP_W-1:0] head_uop,
	input  logic             head_empty,
	input  logic             rd_run_out,
	input  logic             rob_full,
	input  logic             alu_full,
	input  logic             bru_full,
	input  logic             lu_full,
	input  logic             su_full,
	input  logic             st_pending,
	input  logic             ld_pending,
	output logic             head_pop,
	output logic             alloc,
	output logic             rob_push,
	output logic             alu_push,
	output logic             bru_push,
	output logic             lu_push,
	output logic             su_push,
	output func_t            iq_func,
	output pc_t              iq_pc,
	output imm_t             iq_imm
);

	uop_class_t cls;
	arch_reg_t  rd;

	logic is_alu;
	logic is_bru;
	logic is_lu;
	logic is_su;
	logic is_fence;
	logic is_unsup;

	logic       tgt_full;
	logic       issue_ok;
	logic [3:0] pred;
	logic       pred_wr;
	logic       pred_rd;
	logic       fence_hold;
	logic       fence_go;
	logic       unsup_go;

	// unpack the head
	assign cls     = head_uop[CLS_LSB +: $bits(uop_class_t)];
	assign iq_func = head_uop[FUNC_LSB +: $bits(func_t)];
	assign iq_pc   = head_uop[PC_LSB +: $bits(pc_t)];
	assign iq_imm  = head_uop[IMM_LSB +: $bits(imm_t)];
	assign rd      = head_uop[RD_LSB +: AR_W];

	// class decode
	assign is_alu   = (cls == CLS_ALU);
	assign is_bru   = (cls == CLS_BRU);
	assign is_lu    = (cls == CLS_LU);
	assign is_su    = (cls == CLS_SU);
	assign is_fence = (cls == CLS_FENCE);
	// any class code without a queue is dropped like mret or ebreak
	assign is_unsup = !(is_alu | is_bru | is_lu | is_su | is_fence);

	assign tgt_full = (is_alu & alu_full)
	                | (is_bru & bru_full)
	                | (is_lu & lu_full)
	                | (is_su & su_full);

	// needs room in the target queue, the reorder queue and a free rd copy
	assign issue_ok = !head_empty && !is_fence && !is_unsup
	               && !rob_full && !rd_run_out && !tgt_full;

	// predecessor set in imm[7:4], bits are i o r w
	assign pred    = iq_imm[7:4];
	assign pred_wr = pred[2] | pred[0];
	assign pred_rd = pred[3] | pred[1];

	// earlier stores or loads still in flight
	assign fence_hold = (pred_wr & st_pending) | (pred_rd & ld_pending);
	assign fence_go   = !head_empty && is_fence && !fence_hold;
	assign unsup_go   = !head_empty && is_unsup;

	assign alu_push = issue_ok & is_alu;
	assign bru_push = issue_ok & is_bru;
	assign lu_push  = issue_ok & is_lu;
	assign su_push  = issue_ok & is_su;

	// every issued op takes a reorder entry, fences and drops do not
	assign rob_push = issue_ok;
	assign alloc    = issue_ok & (rd != '0);
	assign head_pop = issue_ok | fence_go | unsup_go;

endmodule

`default_nettype wire

//--- rtl/dispatch_top.sv
//**********************************************************
// dispatch stage top
// instruction queue, dispatch control, rename table and
// reorder queue with its commit port
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module dispatch_top
	import uop_pkg::*, rename_pkg::*;
#(
	parameter int IQ_DEPTH  = 4,
	parameter int ROB_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	// decoded micro-op in
	input  logic       in_valid,
	output logic       in_ready,
	input  uop_class_t in_class,
	input  func_t      in_func,
	input  pc_t        in_pc,
	input  imm_t       in_imm,
	input  arch_reg_t  in_rd,
	input  arch_reg_t  in_rs1,
	input  arch_reg_t  in_rs2,
	// shared issue fields
	output func_t      iq_func,
	output pc_t        iq_pc,
	output imm_t       iq_imm,
	output phys_tag_t  iq_rd_tag,
	output phys_tag_t  iq_rs1_tag,
	output phys_tag_t  iq_rs2_tag,
	output logic       alu_push,
	input  logic       alu_full,
	output logic       bru_push,
	input  logic       bru_full,
	output logic       lu_push,
	input  logic       lu_full,
	output logic       su_push,
	input  logic       su_full,
	// memory status for fences
	input  logic       st_pending,
	input  logic       ld_pending,
	// commit
	input  logic       commit_valid,
	output logic       rob_empty,
	output pc_t        commit_pc,
	output phys_tag_t  commit_rd_tag
);

	logic [UOP_W-1:0] in_uop;
	logic [UOP_W-1:0] head_uop;
	logic             iq_full;
	logic             iq_empty;
	logic             head_pop;
	logic             alloc;
	logic             rd_run_out;
	logic             rob_push;
	logic             rob_full;
	logic [ROB_W-1:0] rob_in;
	logic [ROB_W-1:0] rob_head;
	phys_tag_t        prev_tag;
	logic             commit_fire;
	logic             rel_valid;

	assign in_uop   = {in_class, in_func, in_pc, in_imm, in_rd, in_rs1, in_rs2};
	assign in_ready = !iq_full;

	sync_fifo #(.DEPTH(IQ_DEPTH), .WIDTH(UOP_W)) instr_q (
		.clk(clk), .rst_n(rst_n),
		.push(in_valid & in_ready), .pop(head_pop),
		.wdata(in_uop), .rdata(head_uop),
		.full(iq_full), .empty(iq_empty)
	);

	dispatch u_dispatch (
		.head_uop(head_uop), .head_empty(iq_empty),
		.rd_run_out(rd_run_out), .rob_full(rob_full),
		.alu_full(alu_full), .bru_full(bru_full), .lu_full(lu_full), .su_full(su_full),
		.st_pending(st_pending), .ld_pending(ld_pending),
		.head_pop(head_pop), .alloc(alloc), .rob_push(rob_push),
		.alu_push(alu_push), .bru_push(bru_push), .lu_push(lu_push), .su_push(su_push),
		.iq_func(iq_func), .iq_pc(iq_pc), .iq_imm(iq_imm)
	);

	rename u_rename (
		.clk(clk), .rst_n(rst_n),
		.rs1(head_uop[RS1_LSB +: AR_W]), .rs2(head_uop[RS2_LSB +: AR_W]),
		.rd(head_uop[RD_LSB +: AR_W]), .alloc(alloc),
		.rs1_tag(iq_rs1_tag), .rs2_tag(iq_rs2_tag),
		.rd_tag(iq_rd_tag), .prev_tag(prev_tag), .run_out(rd_run_out),
		.release_valid(rel_valid), .release_tag(rob_head[ROB_PREV_LSB +: TAG_W])
	);

	// has_rd is the allocate strobe itself
	assign rob_in = {iq_pc, alloc, iq_rd_tag, prev_tag};

	sync_fifo #(.DEPTH(ROB_DEPTH), .WIDTH(ROB_W)) rob_q (
		.clk(clk), .rst_n(rst_n),
		.push(rob_push), .pop(commit_fire),
		.wdata(rob_in), .rdata(rob_head),
		.full(rob_full), .empty(rob_empty)
	);

	// retire the head and free the copy it replaced
	assign commit_fire   = commit_valid & !rob_empty;
	assign rel_valid     = commit_fire & rob_head[ROB_HAS_RD];
	assign commit_pc     = rob_head[ROB_PC_LSB +: $bits(pc_t)];
	assign commit_rd_tag = rob_head[ROB_NEW_LSB +: TAG_W];

endmodule

`default_nettype wire

//--- rtl/rename.sv
//**********************************************************
// rename table for the dispatch stage
// active-copy table plus busy bitmap per architectural reg
// source lookup, lowest-free destination copy, commit free
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module rename
	import uop_pkg::*, rename_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  arch_reg_t rs1,
	input  arch_reg_t rs2,
	input  arch_reg_t rd,
	input  logic      alloc,
	output phys_tag_t rs1_tag,
	output phys_tag_t rs2_tag,
	output phys_tag_t rd_tag,
	output phys_tag_t prev_tag,
	output logic      run_out,
	input  logic      release_valid,
	input  phys_tag_t release_tag
);

	localparam int NREG = 2 ** AR_W;

	// current copy of each register
	copy_idx_t            act [NREG];
	// copies still holding a live value
	logic [RN_COPIES-1:0] busy [NREG];

	copy_idx_t free_idx;
	logic      rd_is_x0;
	arch_reg_t rel_reg;
	copy_idx_t rel_copy;

	assign rd_is_x0 = (rd == '0);
	assign {rel_reg, rel_copy} = release_tag;

	// sources read the active copy, x0 stays on copy 0
	assign rs1_tag  = {rs1, act[rs1]};
	assign rs2_tag  = {rs2, act[rs2]};
	assign prev_tag = {rd, act[rd]};

	// lowest free copy of rd
	always_comb begin
		free_idx = '0;
		for (int i = RN_COPIES - 1; i >= 0; i--) begin
			if (!busy[rd][i]) begin
				free_idx = copy_idx_t'(i);
			end
		end
	end

	assign rd_tag  = rd_is_x0 ? '0 : {rd, free_idx};
	assign run_out = !rd_is_x0 && (&busy[rd]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < NREG; r++) begin
				act[r]  <= '0;
				busy[r] <= RN_COPIES'(1);
			end
		end else begin
			// retired instruction gives back its previous copy
			if (release_valid) begin
				busy[rel_reg][rel_copy] <= 1'b0;
			end
			// a free copy never collides with the one being released
			if (alloc && !rd_is_x0) begin
				busy[rd][free_idx] <= 1'b1;
				act[rd]            <= free_idx;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rename_pkg.sv
//**********************************************************
// register renaming definitions
// copy count, physical tags and the reorder entry layout
//**********************************************************
`default_nettype none

package rename_pkg;

	// copies kept per architectural register
	localparam int RN_COPIES = 4;
	localparam int CP_W      = $clog2(RN_COPIES);

	// tag is the architectural index followed by the copy index
	localparam int TAG_W = uop_pkg::AR_W + CP_W;

	typedef logic [CP_W-1:0]  copy_idx_t;
	typedef logic [TAG_W-1:0] phys_tag_t;

	// reorder entry, msb first: pc has_rd new_tag prev_tag
	localparam int ROB_PREV_LSB = 0;
	localparam int ROB_NEW_LSB  = ROB_PREV_LSB + TAG_W;
	localparam int ROB_HAS_RD   = ROB_NEW_LSB + TAG_W;
	localparam int ROB_PC_LSB   = ROB_HAS_RD + 1;
	localparam int ROB_W        = ROB_PC_LSB + $bits(uop_pkg::pc_t);

endpackage

`default_nettype wire

//--- rtl/sync_fifo.sv
//**********************************************************
// synchronous FIFO with push/full and pop/empty handshake
// full and empty are registered and come up busy in reset
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] wdata,
	output logic [WIDTH-1:0] rdata,
	output logic             full,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic [CW-1:0]    count_nxt;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// head is read straight out of the array
	assign rdata = mem[rd_ptr];

	always_comb begin
		count_nxt = count;
		if (push && !pop) begin
			count_nxt = count + 1'b1;
		end else if (pop && !push) begin
			count_nxt = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			// full held high so the writer stays off until the first edge
			full   <= 1'b1;
			empty  <= 1'b1;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count_nxt;
			full  <= (count_nxt == CW'(DEPTH));
			empty <= (count_nxt == '0);
		end
	end

endmodule

`default_nettype wire

//--- rtl/uop_pkg.sv
//**********************************************************
// micro-op encodings for the dispatch stage
// class codes, field types and the instruction queue entry
//**********************************************************
`default_nettype none

package uop_pkg;

	typedef logic [2:0]  uop_class_t;
	typedef logic [5:0]  func_t;
	typedef logic [4:0]  arch_reg_t;
	typedef logic [63:0] pc_t;
	typedef logic [63:0] imm_t;

	// issue class of a decoded micro-op
	localparam uop_class_t CLS_ALU   = 3'd0;
	localparam uop_class_t CLS_BRU   = 3'd1;
	localparam uop_class_t CLS_LU    = 3'd2;
	localparam uop_class_t CLS_SU    = 3'd3;
	localparam uop_class_t CLS_FENCE = 3'd4;
	localparam uop_class_t CLS_UNSUP = 3'd5;

	// function codes within a class
	localparam func_t FN_ADD = 6'd0;
	localparam func_t FN_SUB = 6'd1;
	localparam func_t FN_XOR = 6'd2;
	localparam func_t FN_SLL = 6'd3;
	localparam func_t FN_BEQ = 6'd8;
	localparam func_t FN_BNE = 6'd9;
	localparam func_t FN_LW  = 6'd16;
	localparam func_t FN_LD  = 6'd17;
	localparam func_t FN_SW  = 6'd24;
	localparam func_t FN_SD  = 6'd25;

	// entry layout, msb first: class func pc imm rd rs1 rs2
	localparam int AR_W     = $bits(arch_reg_t);
	localparam int RS2_LSB  = 0;
	localparam int RS1_LSB  = RS2_LSB + AR_W;
	localparam int RD_LSB   = RS1_LSB + AR_W;
	localparam int IMM_LSB  = RD_LSB + AR_W;
	localparam int PC_LSB   = IMM_LSB + $bits(imm_t);
	localparam int FUNC_LSB = PC_LSB + $bits(pc_t);
	localparam int CLS_LSB  = FUNC_LSB + $bits(func_t);
	localparam int UOP_W    = CLS_LSB + $bits(uop_class_t);

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vdispatch_tb

if ! verilator --binary --timing --assert -j 0 --top-module dispatch_tb -f filelist.f; then
	echo "verilator compile failed"
	exit 1
fi

if ! "$BIN" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error status"
	exit 1
fi
cat "$LOG"

# the testbench prints its fail line on any failed check or timeout
if grep -q "Something failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"
exit 0
